// File: Makefile
VERILATOR ?= verilator
TOP       ?= mini51_tb
BUILD     ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: design/cpu_datapath.sv
`timescale 1ns/1ns

module cpu_datapath import mini51_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  instr_t     i_instr,
   input  logic [7:0] i_code_data,
   input  logic [7:0] i_reg_rdata,
   input  logic       i_tx_busy,
   output dp_flags_t  o_flags,
   output reg_port_t  o_reg,
   output logic [2:0] o_reg_raddr,
   output logic       o_tx_start,
   output logic [7:0] o_tx_byte
);

   logic [7:0]  op;
   logic [7:0]  imm;
   logic        exec;
   logic [7:0]  acc;
   logic [7:0]  acc_next;
   logic        acc_wr;
   logic        carry;
   logic        carry_next;
   logic        carry_wr;
   logic [15:0] dptr;
   logic [8:0]  add_res;
   logic [8:0]  sub_res;
   logic [7:0]  reg_dec;
   logic        status_bit;
   logic        is_mov_ra;
   logic        is_mov_ri;
   logic        is_mov_ar;
   logic        is_djnz;

   assign op   = i_instr.op;
   assign imm  = i_instr.h_data;
   assign exec = (i_instr.state == ST_EXECUTE);

   assign is_mov_ra = op_reg_form(op, OP_MOV_RA);
   assign is_mov_ri = op_reg_form(op, OP_MOV_RI);
   assign is_mov_ar = op_reg_form(op, OP_MOV_AR);
   assign is_djnz   = op_reg_form(op, OP_DJNZ_R);

   //////////////////////////////
   // alu

   assign add_res    = {1'b0, acc} + {1'b0, imm};
   assign sub_res    = {1'b0, acc} - {1'b0, imm} - {8'd0, carry};   // borrow out in bit 8
   assign status_bit = (dptr == STATUS_ADDR) & i_tx_busy;

   always_comb begin
      acc_wr = 1'b1;
      case (op)
         OP_MOV_AI:  acc_next = imm;
         OP_ADD_I:   acc_next = add_res[7:0];
         OP_SUBB_I:  acc_next = sub_res[7:0];
         OP_ANL_I:   acc_next = acc & imm;
         OP_ORL_I:   acc_next = acc | imm;
         OP_XRL_I:   acc_next = acc ^ imm;
         OP_INC_A:   acc_next = acc + 8'd1;
         OP_DEC_A:   acc_next = acc - 8'd1;
         OP_CLR_A:   acc_next = 8'd0;
         OP_CPL_A:   acc_next = ~acc;
         OP_MOVX_AD: acc_next = {7'd0, status_bit};   // any other address reads 0
         default: begin
            acc_next = i_reg_rdata;
            acc_wr   = is_mov_ar;
         end
      endcase
   end

   always_comb begin
      carry_wr = 1'b1;
      case (op)
         OP_ADD_I:  carry_next = add_res[8];
         OP_SUBB_I: carry_next = sub_res[8];
         OP_CLR_C:  carry_next = 1'b0;
         OP_SETB_C: carry_next = 1'b1;
         default: begin
            carry_next = carry;
            carry_wr   = 1'b0;
         end
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         acc   <= 8'd0;
         carry <= 1'b0;
      end else if (exec) begin
         if (acc_wr) acc <= acc_next;
         if (carry_wr) carry <= carry_next;
      end
   end

   // dpl still on the code bus in decode2 while dph is already latched
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         dptr <= 16'd0;
      end else if (i_instr.state == ST_DECODE2 && op == OP_MOV_DP) begin
         dptr <= {imm, i_code_data};
      end
   end

   //////////////////////////////
   // register file and uart

   assign reg_dec     = i_reg_rdata - 8'd1;
   assign o_reg_raddr = op[2:0];

   assign o_reg.wr    = exec & (is_mov_ra | is_mov_ri | is_djnz);
   assign o_reg.addr  = op[2:0];
   assign o_reg.wdata = is_mov_ra ? acc :
                        is_mov_ri ? imm : reg_dec;   // djnz

   assign o_flags.acc_zero              = (acc == 8'd0);
   assign o_flags.carry                 = carry;
   assign o_flags.reg_nonzero_after_dec = (reg_dec != 8'd0);

   assign o_tx_start = exec & (op == OP_MOVX_DA) & (dptr == TX_ADDR);
   assign o_tx_byte  = acc;

   // execute lasts one cycle so start is a single pulse
   a_tx_pulse: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_tx_start |=> !o_tx_start);

endmodule

// File: design/cpu_pc.sv
`timescale 1ns/1ns

module cpu_pc import mini51_pkg::*; (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  instr_t             i_instr,
   input  dp_flags_t          i_flags,
   input  logic [7:0]         i_code_data,
   input  logic               i_boot_done,
   output logic [CODE_AW-1:0] o_pc
);

   logic [1:0]         len;
   logic               exec;
   logic               inc;
   logic               taken;
   logic [15:0]        target;
   logic [CODE_AW-1:0] rel;
   logic [CODE_AW-1:0] pc_next;

   assign exec = (i_instr.state == ST_EXECUTE);

   // the opcode is not latched yet in decode0
   assign len = (i_instr.state == ST_DECODE0) ? op_bytes(i_code_data) : op_bytes(i_instr.op);

   // one step per byte consumed, execute sees the next instruction address
   assign inc = ((i_instr.state == ST_FETCH)   & i_boot_done) |
                ((i_instr.state == ST_DECODE0) & (len != 2'd1)) |
                ((i_instr.state == ST_DECODE1) & (len == 2'd3));

   assign taken = exec & (
      (i_instr.op == OP_SJMP) |
      ((i_instr.op == OP_JZ)  &  i_flags.acc_zero) |
      ((i_instr.op == OP_JNZ) & ~i_flags.acc_zero) |
      ((i_instr.op == OP_JC)  &  i_flags.carry) |
      ((i_instr.op == OP_JNC) & ~i_flags.carry) |
      (op_reg_form(i_instr.op, OP_DJNZ_R) & i_flags.reg_nonzero_after_dec));

   assign target = {i_instr.h_data, i_instr.l_data};
   assign rel    = {{(CODE_AW - 8){i_instr.h_data[7]}}, i_instr.h_data};   // sign extend

   assign pc_next = (exec && i_instr.op == OP_LJMP) ? target[CODE_AW-1:0] :
                    taken                           ? o_pc + rel :
                    inc                             ? o_pc + 1'b1 : o_pc;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         o_pc <= '0;
      end else begin
         o_pc <= pc_next;
      end
   end

endmodule

// File: design/cpu_sequencer.sv
`timescale 1ns/1ns

module cpu_sequencer import mini51_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_boot_done,
   input  logic [7:0] i_code_data,
   output instr_t     o_instr
);

   cpu_state_e state;
   cpu_state_e state_next;
   logic [7:0] op_q;
   logic [7:0] h_q;
   logic [7:0] l_q;

   //////////////////////////////
   // state sequence

   // instruction length picks the number of decode states
   always_comb begin
      state_next = state;
      case (state)
         ST_FETCH: begin
            if (i_boot_done) state_next = ST_DECODE0;
         end
         ST_DECODE0: begin
            // opcode is only on the code bus in this state
            if (op_bytes(i_code_data) == 2'd1) begin
               state_next = ST_EXECUTE;
            end else begin
               state_next = ST_DECODE1;
            end
         end
         ST_DECODE1: begin
            if (op_bytes(op_q) == 2'd3) begin
               state_next = ST_DECODE2;
            end else begin
               state_next = ST_EXECUTE;
            end
         end
         ST_DECODE2: state_next = ST_EXECUTE;
         default:    state_next = ST_FETCH;
      endcase
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= ST_FETCH;
      end else begin
         state <= state_next;
      end
   end

   //////////////////////////////
   // opcode and operand capture

   always_ff @(posedge i_clk) begin
      case (state)
         ST_DECODE0: op_q <= i_code_data;
         ST_DECODE1: h_q  <= i_code_data;   // imm, rel or high address byte
         ST_DECODE2: l_q  <= i_code_data;
         default: ;
      endcase
   end

   assign o_instr.state  = state;
   assign o_instr.op     = op_q;
   assign o_instr.h_data = h_q;
   assign o_instr.l_data = l_q;

   // core only runs once the loader has finished
   a_run_after_boot: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (state != ST_FETCH) |-> i_boot_done);

endmodule

// File: design/mini51_pkg.sv
package mini51_pkg;

   // uart bit timing, kept short for simulation
   localparam int BIT_CYCLES = 16;
   localparam int BIT_HALF   = BIT_CYCLES / 2;
   localparam int BIT_CNT_W  = $clog2(BIT_CYCLES);
   localparam int LOAD_BYTES = 64;

   localparam int CODE_AW = 10;

   localparam logic [5:0]  REG_BANK_BASE = 6'h3f;   // bank 0 at the top of the reg space
   localparam logic [15:0] STATUS_ADDR   = 16'h0200;
   localparam logic [15:0] TX_ADDR       = 16'h0201;

   //////////////////////////////
   // opcodes, 8051 encodings

   localparam logic [7:0] OP_LJMP    = 8'h02;
   localparam logic [7:0] OP_INC_A   = 8'h04;
   localparam logic [7:0] OP_DEC_A   = 8'h14;
   localparam logic [7:0] OP_ADD_I   = 8'h24;
   localparam logic [7:0] OP_JC      = 8'h40;
   localparam logic [7:0] OP_ORL_I   = 8'h44;
   localparam logic [7:0] OP_JNC     = 8'h50;
   localparam logic [7:0] OP_ANL_I   = 8'h54;
   localparam logic [7:0] OP_JZ      = 8'h60;
   localparam logic [7:0] OP_XRL_I   = 8'h64;
   localparam logic [7:0] OP_JNZ     = 8'h70;
   localparam logic [7:0] OP_MOV_AI  = 8'h74;
   localparam logic [7:0] OP_MOV_RI  = 8'h78;   // + r
   localparam logic [7:0] OP_SJMP    = 8'h80;
   localparam logic [7:0] OP_MOV_DP  = 8'h90;
   localparam logic [7:0] OP_SUBB_I  = 8'h94;
   localparam logic [7:0] OP_CLR_C   = 8'hc3;
   localparam logic [7:0] OP_SETB_C  = 8'hd3;
   localparam logic [7:0] OP_DJNZ_R  = 8'hd8;   // + r
   localparam logic [7:0] OP_MOVX_AD = 8'he0;
   localparam logic [7:0] OP_CLR_A   = 8'he4;
   localparam logic [7:0] OP_MOV_AR  = 8'he8;   // + r
   localparam logic [7:0] OP_MOVX_DA = 8'hf0;
   localparam logic [7:0] OP_CPL_A   = 8'hf4;
   localparam logic [7:0] OP_MOV_RA  = 8'hf8;   // + r

   typedef enum logic [2:0] {
      ST_FETCH   = 3'd0,
      ST_DECODE0 = 3'd1,
      ST_DECODE1 = 3'd2,
      ST_DECODE2 = 3'd3,
      ST_EXECUTE = 3'd4
   } cpu_state_e;

   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_SEND} tx_state_e;

   typedef struct packed {
      cpu_state_e state;
      logic [7:0] op;
      logic [7:0] h_data;
      logic [7:0] l_data;
   } instr_t;

   typedef struct packed {
      logic acc_zero;
      logic carry;
      logic reg_nonzero_after_dec;
   } dp_flags_t;

   typedef struct packed {
      logic       wr;
      logic [2:0] addr;
      logic [7:0] wdata;
   } reg_port_t;

   // register forms carry r in the low three bits
   function automatic logic op_reg_form(input logic [7:0] op, input logic [7:0] base);
      return op[7:3] == base[7:3];
   endfunction

   function automatic logic [1:0] op_bytes(input logic [7:0] op);
      if (op == OP_LJMP || op == OP_MOV_DP) begin
         return 2'd3;
      end
      if (op inside {OP_MOV_AI, OP_ADD_I, OP_SUBB_I, OP_ANL_I, OP_ORL_I, OP_XRL_I,
                     OP_SJMP, OP_JZ, OP_JNZ, OP_JC, OP_JNC} ||
          op_reg_form(op, OP_MOV_RI) || op_reg_form(op, OP_DJNZ_R)) begin
         return 2'd2;
      end
      return 2'd1;
   endfunction

endpackage

// File: design/mini51_top.sv
`timescale 1ns/1ns

module mini51_top import mini51_pkg::*; (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic               i_uart_rx,
   input  logic [7:0]         i_code_data,
   input  logic [7:0]         i_reg_rdata,
   output logic               o_uart_tx,
   output logic               o_code_wr,
   output logic [CODE_AW-1:0] o_code_addr,
   output logic [7:0]         o_code_data,
   output logic               o_reg_wr,
   output logic [8:0]         o_reg_waddr,
   output logic [8:0]         o_reg_raddr,
   output logic [7:0]         o_reg_wdata
);

   logic               boot_done;
   logic [CODE_AW-1:0] ld_addr;
   instr_t             instr;
   dp_flags_t          flags;
   reg_port_t          reg_port;
   logic [2:0]         reg_raddr;
   logic               tx_start;
   logic [7:0]         tx_byte;
   logic               tx_busy;
   logic [CODE_AW-1:0] pc;

   uart_boot_loader loader_i (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_uart_rx(i_uart_rx),
      .o_code_wr(o_code_wr), .o_code_waddr(ld_addr), .o_code_wdata(o_code_data),
      .o_boot_done(boot_done));

   cpu_sequencer seq_i (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_boot_done(boot_done),
      .i_code_data(i_code_data), .o_instr(instr));

   cpu_datapath dp_i (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_instr(instr), .i_code_data(i_code_data),
      .i_reg_rdata(i_reg_rdata), .i_tx_busy(tx_busy), .o_flags(flags), .o_reg(reg_port),
      .o_reg_raddr(reg_raddr), .o_tx_start(tx_start), .o_tx_byte(tx_byte));

   cpu_pc pc_i (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_instr(instr), .i_flags(flags),
      .i_code_data(i_code_data), .i_boot_done(boot_done), .o_pc(pc));

   uart_tx tx_i (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_start(tx_start), .i_byte(tx_byte),
      .o_busy(tx_busy), .o_tx(o_uart_tx));

   assign o_code_addr = boot_done ? pc : ld_addr;   // loader owns the bus until boot done

   assign o_reg_wr    = reg_port.wr;
   assign o_reg_waddr = {REG_BANK_BASE, reg_port.addr};
   assign o_reg_raddr = {REG_BANK_BASE, reg_raddr};
   assign o_reg_wdata = reg_port.wdata;

endmodule

// File: design/uart_boot_loader.sv
`timescale 1ns/1ns

module uart_boot_loader import mini51_pkg::*; (
   input  logic               i_clk,
   input  logic               i_nrst,
   input  logic               i_uart_rx,
   output logic               o_code_wr,
   output logic [CODE_AW-1:0] o_code_waddr,
   output logic [7:0]         o_code_wdata,
   output logic               o_boot_done
);

   logic [1:0]           rx_sync;
   logic                 rx;
   rx_state_e            state;
   logic [BIT_CNT_W-1:0] cnt;
   logic                 half_tick;
   logic                 full_tick;
   logic                 byte_done;
   logic [7:0]           shreg;
   logic [CODE_AW-1:0]   byte_cnt;

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         rx_sync <= 2'b11;   // idle line
      end else begin
         rx_sync <= {rx_sync[0], i_uart_rx};
      end
   end

   assign rx        = rx_sync[1];
   assign half_tick = (cnt == BIT_CNT_W'(BIT_HALF - 1));
   assign full_tick = (cnt == BIT_CNT_W'(BIT_CYCLES - 1));
   assign byte_done = (state == RX_STOP) && full_tick;

   //////////////////////////////
   // receive fsm

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state <= RX_IDLE;
         cnt   <= '0;
      end else begin
         cnt <= cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               cnt <= '0;
               if (!rx) state <= RX_START;
            end
            RX_START: begin
               if (half_tick) begin
                  cnt   <= '0;
                  state <= rx ? RX_IDLE : RX_DATA;   // false start if high again at mid bit
               end
            end
            RX_DATA: begin
               if (full_tick) begin
                  cnt <= '0;
                  if (shreg[0]) state <= RX_STOP;
               end
            end
            RX_STOP: begin
               if (full_tick) state <= RX_IDLE;
            end
         endcase
      end
   end

   // lsb first with a marker bit that falls out after the eighth sample
   always_ff @(posedge i_clk) begin
      if (state == RX_START && half_tick) begin
         shreg <= 8'h80;
      end else if (state == RX_DATA && full_tick) begin
         shreg <= {rx, shreg[7:1]};
      end
   end

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         byte_cnt    <= '0;
         o_boot_done <= 1'b0;
      end else if (byte_done && !o_boot_done) begin
         byte_cnt <= byte_cnt + 1'b1;
         if (byte_cnt == CODE_AW'(LOAD_BYTES - 1)) o_boot_done <= 1'b1;
      end
   end

   assign o_code_wr    = byte_done & ~o_boot_done;   // late bytes dropped
   assign o_code_waddr = byte_cnt;
   assign o_code_wdata = shreg;

   // no write lands past the loaded area
   a_wr_in_range: assert property (@(posedge i_clk) disable iff (!i_nrst)
      o_code_wr |-> (o_code_waddr < CODE_AW'(LOAD_BYTES)));

endmodule

// File: design/uart_tx.sv
`timescale 1ns/1ns

module uart_tx import mini51_pkg::*; (
   input  logic       i_clk,
   input  logic       i_nrst,
   input  logic       i_start,
   input  logic [7:0] i_byte,
   output logic       o_busy,
   output logic       o_tx
);

   tx_state_e            state;
   logic [BIT_CNT_W-1:0] cnt;
   logic [3:0]           bit_cnt;
   logic [8:0]           sh;       // start bit on top, then data msb first
   logic                 tick;

   assign tick = (cnt == BIT_CNT_W'(BIT_CYCLES - 1));

   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         state   <= TX_IDLE;
         cnt     <= '0;
         bit_cnt <= '0;
      end else begin
         cnt <= tick ? '0 : cnt + 1'b1;
         case (state)
            TX_IDLE: begin
               cnt     <= '0;
               bit_cnt <= '0;
               if (i_start) state <= TX_START;   // a start while busy is simply lost
            end
            TX_START: begin
               if (tick) state <= TX_SEND;
            end
            default: begin
               if (tick) begin
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == 4'd8) state <= TX_IDLE;   // 8 data + stop
               end
            end
         endcase
      end
   end

   // ones shift in behind the data, giving stop bit and idle level
   always_ff @(posedge i_clk or negedge i_nrst) begin
      if (!i_nrst) begin
         sh <= '1;
      end else if (state == TX_IDLE && i_start) begin
         sh <= {1'b0, i_byte};
      end else if (state != TX_IDLE && tick) begin
         sh <= {sh[7:0], 1'b1};
      end
   end

   assign o_tx   = sh[8];
   assign o_busy = (state != TX_IDLE);

   a_idle_high: assert property (@(posedge i_clk) disable iff (!i_nrst)
      (state == TX_IDLE) |-> o_tx);

endmodule

// File: verification/mini51_tb.sv
`timescale 1ns/1ns

module mini51_tb import mini51_pkg::*; ();

   localparam int LOAD_CYCLES = (LOAD_BYTES + 1) * 10 * BIT_CYCLES;
   localparam int RUN_CYCLES  = 3000;                          // longest program plus settle
   localparam int N_LOADS     = 6;
   localparam int MAX_CYCLES  = N_LOADS * (LOAD_CYCLES + RUN_CYCLES + 100);

   typedef struct packed {
      logic [CODE_AW-1:0] addr;
      logic [7:0]         data;
   } code_wr_t;

   typedef struct packed {
      logic [8:0] addr;
      logic [7:0] data;
   } reg_wr_t;

   logic               i_clk;
   logic               i_nrst;
   logic               i_uart_rx;
   logic [7:0]         code_rdata;
   logic [7:0]         reg_rdata;
   logic               uart_tx;
   logic               code_wr;
   logic [CODE_AW-1:0] code_addr;
   logic [7:0]         code_wdata;
   logic               reg_wr;
   logic [8:0]         reg_waddr;
   logic [8:0]         reg_raddr;
   logic [7:0]         reg_wdata;

   logic [7:0]  code_mem [1024];
   logic [7:0]  reg_mem [8];
   logic [7:0]  prog [LOAD_BYTES];
   int          plen;
   logic [31:0] lfsr = 32'hde7c;
   int          cycles;
   int          errors;
   int          checks;
   int          tests;
   code_wr_t    code_wr_q [$];
   reg_wr_t     reg_wr_q [$];
   logic [7:0]  rx_q [$];
   logic [7:0]  exp_q [$];

   mini51_top mini51_i (
      .i_clk(i_clk), .i_nrst(i_nrst), .i_uart_rx(i_uart_rx),
      .i_code_data(code_rdata), .i_reg_rdata(reg_rdata),
      .o_uart_tx(uart_tx), .o_code_wr(code_wr), .o_code_addr(code_addr),
      .o_code_data(code_wdata), .o_reg_wr(reg_wr), .o_reg_waddr(reg_waddr),
      .o_reg_raddr(reg_raddr), .o_reg_wdata(reg_wdata));

   initial begin
      i_clk = 1'b0;
      forever #2 i_clk = ~i_clk;
   end

   //////////////////////////////
   // memory models and monitors

   initial begin
      code_rdata = 8'd0;
      for (int a = 0; a < 1024; a++) code_mem[a] = 8'(a ^ (a >> 3));
      for (int r = 0; r < 8; r++) reg_mem[r] = 8'd0;
   end

   always @(posedge i_clk) begin
      if (code_wr) code_mem[code_addr] <= code_wdata;
      code_rdata <= code_mem[code_addr];   // one cycle read latency
      if (reg_wr) reg_mem[reg_waddr[2:0]] <= reg_wdata;
   end

   // bank 0 sits at 9'h1f8, anything else reads 0
   assign reg_rdata = (reg_raddr[8:3] == 6'h3f) ? reg_mem[reg_raddr[2:0]] : 8'h00;

   always @(negedge i_clk) begin
      if (i_nrst && code_wr) code_wr_q.push_back({code_addr, code_wdata});
      if (i_nrst && reg_wr) reg_wr_q.push_back({reg_waddr, reg_wdata});
   end

   // uart receiver sampling msb first at mid bit
   initial begin
      logic [7:0] b;
      forever begin
         @(negedge i_clk);
         if (i_nrst && uart_tx === 1'b0) begin
            repeat (BIT_HALF) @(negedge i_clk);
            b = 8'd0;
            for (int i = 0; i < 8; i++) begin
               repeat (BIT_CYCLES) @(negedge i_clk);
               b = {b[6:0], uart_tx};
            end
            repeat (BIT_CYCLES) @(negedge i_clk);
            if (uart_tx !== 1'b1) begin
               $display("uart frame error at %0t: stop bit was low", $time);
               errors++;
            end
            rx_q.push_back(b);
         end
      end
   end

   always @(posedge i_clk) begin
      cycles <= cycles + 1;
      if (cycles > MAX_CYCLES) begin
         $display("timeout after %0d cycles, the DUT stopped responding", cycles);
         $display("TEST FAIL");
         $finish;
      end
   end

   //////////////////////////////
   // helpers

   function automatic logic [7:0] rand_byte();
      logic [7:0] b;
      b = 8'd0;
      for (int i = 0; i < 8; i++) begin
         b = {b[6:0], lfsr[0]};
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);   // galois step
      end
      return b;
   endfunction

   task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   task automatic reset_dut();
      @(posedge i_clk);
      #1 i_nrst = 1'b0;
      repeat (4) @(posedge i_clk);
      #1 i_nrst = 1'b1;
      rx_q.delete();
      reg_wr_q.delete();
      code_wr_q.delete();
   endtask

   task automatic send_byte(input logic [7:0] b);
      @(posedge i_clk);
      #1 i_uart_rx = 1'b0;   // start bit
      repeat (BIT_CYCLES) @(posedge i_clk);
      for (int i = 0; i < 8; i++) begin
         #1 i_uart_rx = b[i];
         repeat (BIT_CYCLES) @(posedge i_clk);
      end
      #1 i_uart_rx = 1'b1;
      repeat (BIT_CYCLES) @(posedge i_clk);
   endtask

   task automatic emit(input logic [7:0] b);
      prog[plen] = b;
      plen++;
   endtask

   task automatic emit_tx_acc();
      emit(OP_MOV_DP); emit(TX_ADDR[15:8]); emit(TX_ADDR[7:0]);
      emit(OP_MOVX_DA);
   endtask

   // loop of movx a,@dptr and jnz back until the busy flag clears
   task automatic emit_wait_idle();
      emit(OP_MOV_DP); emit(STATUS_ADDR[15:8]); emit(STATUS_ADDR[7:0]);
      emit(OP_MOVX_AD);
      emit(OP_JNZ); emit(8'hfd);
   endtask

   // dptr must already hold TX_ADDR and the r7 delay covers one frame
   task automatic emit_marker(input logic [7:0] m);
      emit(OP_MOV_AI); emit(m);
      emit(OP_MOVX_DA);
      emit(OP_MOV_RI | 8'd7); emit(8'd48);
      emit(OP_DJNZ_R | 8'd7); emit(8'hfe);
   endtask

   task automatic load_program();
      while (plen < LOAD_BYTES - 1) begin
         emit(OP_SJMP);
         emit(8'hfe);
      end
      if (plen < LOAD_BYTES) emit(8'h00);
      code_wr_q.delete();
      for (int i = 0; i < LOAD_BYTES; i++) send_byte(prog[i]);
   endtask

   task automatic check_load();
      check_eq("code write count", code_wr_q.size(), LOAD_BYTES);
      for (int i = 0; i < code_wr_q.size() && i < LOAD_BYTES; i++) begin
         check_eq("code write addr", code_wr_q[i].addr, i);
         check_eq("code write data", code_wr_q[i].data, prog[i]);
      end
   endtask

   task automatic check_rx();
      while (rx_q.size() < exp_q.size()) @(posedge i_clk);
      repeat (600) @(posedge i_clk);   // room for a stray extra byte
      check_eq("uart byte count", rx_q.size(), exp_q.size());
      for (int i = 0; i < rx_q.size() && i < exp_q.size(); i++) begin
         check_eq("uart byte", rx_q[i], exp_q[i]);
      end
   endtask

   task automatic finish_test(input string name, input int err_before);
      tests++;
      $display("%s: done, %0d errors", name, errors - err_before);
   endtask

   //////////////////////////////
   // directed tests

   task automatic test_boot();
      int e0;
      e0 = errors;
      reset_dut();
      plen = 0;
      emit(OP_SJMP); emit(8'hfe);
      while (plen < LOAD_BYTES) emit(rand_byte());
      load_program();
      send_byte(rand_byte());   // late byte must be dropped
      repeat (20) @(posedge i_clk);
      check_load();
      finish_test("boot load", e0);
   endtask

   task automatic test_arith();
      logic [7:0] imm [6];
      logic [7:0] a;
      logic       c;
      int         e0;
      e0 = errors;
      for (int i = 0; i < 6; i++) imm[i] = rand_byte();
      reset_dut();
      plen = 0;
      emit(OP_CLR_C);
      emit(OP_MOV_AI); emit(imm[0]);
      emit(OP_ADD_I);  emit(imm[1]);
      emit(OP_SUBB_I); emit(imm[2]);
      emit(OP_ANL_I);  emit(imm[3]);
      emit(OP_ORL_I);  emit(imm[4]);
      emit(OP_XRL_I);  emit(imm[5]);
      emit(OP_INC_A);
      emit(OP_INC_A);
      emit(OP_DEC_A);
      emit(OP_CPL_A);
      emit_tx_acc();
      load_program();
      check_load();
      a = imm[0] + imm[1];
      c = (int'(imm[0]) + int'(imm[1])) > 255;   // carry out of the add
      a = a - imm[2] - {7'd0, c};
      a = ((a & imm[3]) | imm[4]) ^ imm[5];
      a = ~(a + 8'd1 + 8'd1 - 8'd1);
      exp_q = {a};
      check_rx();
      finish_test("accumulator arithmetic", e0);
   endtask

   task automatic test_regs();
      logic [7:0] x;
      logic [7:0] y;
      int         e0;
      e0 = errors;
      x = rand_byte();
      y = rand_byte();
      reset_dut();
      plen = 0;
      emit(OP_MOV_RI | 8'd2); emit(x);
      emit(OP_MOV_AI); emit(y);
      emit(OP_MOV_RA | 8'd6);
      emit(OP_CLR_A);
      emit(OP_MOV_AR | 8'd2);
      emit_tx_acc();
      emit_wait_idle();
      emit(OP_MOV_AR | 8'd6);
      emit_tx_acc();
      load_program();
      check_load();
      exp_q = {x, y};
      check_rx();
      check_eq("reg write count", reg_wr_q.size(), 2);
      if (reg_wr_q.size() == 2) begin
         check_eq("reg write 0", reg_wr_q[0], {9'h1fa, x});
         check_eq("reg write 1", reg_wr_q[1], {9'h1fe, y});
      end
      finish_test("register file", e0);
   endtask

   task automatic test_branches();
      int e0;
      e0 = errors;
      // djnz loop, jz and jnz taken, jz not taken, sjmp
      reset_dut();
      plen = 0;
      emit(OP_MOV_DP); emit(TX_ADDR[15:8]); emit(TX_ADDR[7:0]);
      emit(OP_MOV_RI | 8'd1); emit(8'd3);
      emit(OP_MOV_AR | 8'd1);             // loop head at 5
      emit(OP_MOVX_DA);
      emit(OP_MOV_RI | 8'd7); emit(8'd48);
      emit(OP_DJNZ_R | 8'd7); emit(8'hfe);
      emit(OP_DJNZ_R | 8'd1); emit(8'hf8);
      emit(OP_CLR_A);
      emit(OP_JZ); emit(8'd1);
      emit(OP_MOVX_DA);
      emit_marker(8'ha1);
      emit(OP_JNZ); emit(8'd1);
      emit(OP_MOVX_DA);
      emit_marker(8'ha2);
      emit(OP_JZ); emit(8'd7);
      emit_marker(8'ha3);
      emit(OP_SJMP); emit(8'd1);
      emit(OP_MOVX_DA);
      emit_marker(8'ha4);
      load_program();
      check_load();
      exp_q = {8'h03, 8'h02, 8'h01, 8'ha1, 8'ha2, 8'ha3, 8'ha4};
      check_rx();
      // carry branches both ways and ljmp
      reset_dut();
      plen = 0;
      emit(OP_MOV_DP); emit(TX_ADDR[15:8]); emit(TX_ADDR[7:0]);
      emit(OP_CLR_C);
      emit(OP_JNC); emit(8'd1);
      emit(OP_MOVX_DA);
      emit_marker(8'hb1);
      emit(OP_SETB_C);
      emit(OP_JC); emit(8'd1);
      emit(OP_MOVX_DA);
      emit_marker(8'hb2);
      emit(OP_CLR_C);
      emit(OP_JC); emit(8'd7);
      emit_marker(8'hb3);
      emit(OP_SETB_C);
      emit(OP_JNC); emit(8'd7);
      emit_marker(8'hb4);
      emit(OP_LJMP); emit(8'h00); emit(8'h31);   // jumps to 49
      emit(OP_MOVX_DA);
      emit_marker(8'hb5);
      load_program();
      check_load();
      exp_q = {8'hb1, 8'hb2, 8'hb3, 8'hb4, 8'hb5};
      check_rx();
      finish_test("branches", e0);
   endtask

   task automatic test_status_poll();
      logic [7:0] v1;
      logic [7:0] v2;
      int         e0;
      e0 = errors;
      v1 = rand_byte();
      v2 = rand_byte();
      reset_dut();
      plen = 0;
      emit_wait_idle();
      emit(OP_MOV_AI); emit(v1);
      emit_tx_acc();
      emit_wait_idle();
      emit(OP_MOV_AI); emit(v2);
      emit_tx_acc();
      load_program();
      check_load();
      exp_q = {v1, v2};
      check_rx();
      finish_test("status poll", e0);
   endtask

   initial begin
      i_nrst    = 1'b0;
      i_uart_rx = 1'b1;
      cycles    = 0;
      errors    = 0;
      checks    = 0;
      tests     = 0;
      test_boot();
      test_arith();
      test_regs();
      test_branches();
      test_status_poll();
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// File: vlog.f
design/mini51_pkg.sv
design/uart_boot_loader.sv
design/uart_tx.sv
design/cpu_sequencer.sv
design/cpu_datapath.sv
design/cpu_pc.sv
design/mini51_top.sv
verification/mini51_tb.sv
